//--- include/warp_settings.svh
`ifndef WARP_SETTINGS_SVH
`define WARP_SETTINGS_SVH

// wait cycles from BACT rising to DTACK falling, RAM and ROM
`define WARP_FAST_WAIT 2

// I/O bus request queue depth, equal to the credits after reset
`define WARP_IO_CREDITS 4

// credit counter width, must hold WARP_IO_CREDITS
`define WARP_CREDIT_W 3

`endif

//--- hdl/warpPkg.sv
package warpPkg;

	// request kinds on the I/O bus
	typedef enum logic [1:0] {
		ioRd = 2'd0, // motherboard read, blocking
		ioWr = 2'd1, // posted write
		ioIack = 2'd2 // interrupt acknowledge, blocking like a read
	} ioOpT;

	// bridge FSM, also brought out as a debug port
	typedef enum logic [2:0] {
		brIdle = 3'd0, // no I/O cycle in progress
		brWaitCredit = 3'd1, // queue full, CPU held off
		brWaitDone = 3'd2, // issued, waiting for in-order completion
		brAck = 3'd3 // DTACK low until the cycle ends
	} bridgeStateT;

	// fast RAM/ROM acknowledge FSM
	typedef enum logic [1:0] {
		faIdle = 2'd0,
		faCount = 2'd1, // wait states running
		faAck = 2'd2 // DTACK held low
	} ackStateT;

endpackage

//--- hdl/cycleDetect.sv
`timescale 1ns/1ps

module cycleDetect (
	input logic CLK,
	input logic nRES,
	input logic nAS, // raw 68000 address strobe
	output logic BACT, // bus cycle active
	output logic cycleEnd // one clock as BACT falls
);

	logic nASr; // first sample of nAS

	// BACT trails the sample by one clock, cycleEnd marks its fall
	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			nASr <= 1'b1;
			BACT <= 1'b0;
			cycleEnd <= 1'b0;
		end else begin
			nASr <= nAS;
			BACT <= ~nASr;
			cycleEnd <= BACT && nASr; // strobe seen high while still active
		end
	end

endmodule

//--- hdl/CS.sv
`timescale 1ns/1ps

module CS (
	input logic FastROMEN, // ROM served on the accelerator
	input logic [23:8] A,
	input logic CLK,
	input logic nRES,
	input logic nWE,
	input logic BACT, // registered address strobe
	output logic IOCS, // cycle goes to the motherboard
	output logic SCSICS,
	output logic IOPWCS, // low-RAM write seen by the motherboard
	output logic IACS, // interrupt acknowledge
	output logic ROMCS,
	output logic RAMCS,
	output logic SndRAMCSWR // sound buffer write snoop
);

	logic nOverlay0; // set by first 4xxxxx access
	logic nOverlay1; // copy taken between cycles
	logic overlay;
	logic romSpace; // 4xxxxx
	logic lowRam; // 000000-3FFFFF
	logic highRam; // 600000-7FFFFF
	logic topWr64k; // write into last 64 KB of RAM
	logic vidWr; // write that hits the video buffer
	logic sndWr;

	assign overlay = ~nOverlay1;
	assign romSpace = A[23:20] == 4'h4;

	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			nOverlay0 <= 1'b0;
			nOverlay1 <= 1'b0; // overlay on out of reset
		end else begin
			if (BACT && romSpace)
				nOverlay0 <= 1'b1;
			if (!BACT)
				nOverlay1 <= nOverlay0; // never mid-cycle
		end
	end

	assign lowRam = A[23:22] == 2'b00;
	assign highRam = A[23:21] == 3'b011;
	assign RAMCS = (lowRam && !overlay) || (highRam && overlay);

	// 3Fxxxx or 7Fxxxx, depending on overlay
	assign topWr64k = RAMCS && A[21:16] == 6'h3F && !nWE;
	// video lives in pages 2-7 and A-F of that 64 KB
	assign vidWr = topWr64k && (A[14] || A[13]);
	assign sndWr = (A[15:12] == 4'hF && A[11:8] >= 4'hD) || // main sound buffer
		(A[15:12] == 4'hA && A[11:8] >= 4'h1 && A[11:8] <= 4'h3); // alternate buffer
	assign SndRAMCSWR = topWr64k && sndWr;

	assign ROMCS = (A[23:20] == 4'h0 && FastROMEN && overlay) ||
		(romSpace && FastROMEN) ||
		(A[23:20] == 4'hC && !FastROMEN);

	assign IACS = A[23:8] == 16'hFFFF;
	assign SCSICS = A[23:20] == 4'h5;

	assign IOCS = (A[23:20] == 4'h0 && !FastROMEN && overlay) || // boot ROM via motherboard
		(romSpace && !FastROMEN) || // motherboard ROM
		SCSICS ||
		A[23:20] == 4'h8 || // empty, bus error from board
		A[23:20] == 4'h9 || // SCC read
		A[23:20] == 4'hA ||
		A[23:20] == 4'hB || // SCC write
		(A[23:20] == 4'hC && FastROMEN) ||
		A[23:20] == 4'hD || // IWM
		A[23:20] == 4'hE || // VIA
		A[23:20] == 4'hF || // IACK page
		vidWr; // snoop, motherboard keeps its copy

	assign IOPWCS = lowRam && !nWE;

endmodule

//--- hdl/fastAck.sv
`timescale 1ns/1ps
`include "warp_settings.svh"

module fastAck (
	input logic CLK,
	input logic nRES,
	input logic BACT,
	input logic RAMCS,
	input logic ROMCS,
	output logic fastDtack // active low
);
	import warpPkg::*;

	localparam int WaitW = $clog2(`WARP_FAST_WAIT + 2);
	localparam logic [WaitW-1:0] WaitTop = `WARP_FAST_WAIT;
	localparam logic [WaitW-1:0] FirstCnt = 2; // first edge counted already passed

	ackStateT state;
	logic [WaitW-1:0] waitCnt; // clocks since BACT rose

	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			state <= faIdle;
			waitCnt <= '0;
		end else begin
			case (state)
				faIdle: if (BACT && (RAMCS || ROMCS)) begin
					waitCnt <= FirstCnt;
					if (`WARP_FAST_WAIT <= 1)
						state <= faAck; // zero wait states
					else
						state <= faCount;
				end
				faCount: if (!BACT)
					state <= faIdle; // aborted cycle
				else if (waitCnt >= WaitTop)
					state <= faAck;
				else
					waitCnt <= waitCnt + 1'b1;
				faAck: if (!BACT)
					state <= faIdle; // released with the strobe
				default: state <= faIdle;
			endcase
		end
	end

	assign fastDtack = state != faAck;

endmodule

//--- hdl/ioBridge.sv
`timescale 1ns/1ps
`include "warp_settings.svh"

module ioBridge (
	input logic CLK,
	input logic nRES,
	input logic BACT,
	input logic cycleEnd,
	input logic IOCS,
	input logic IACS,
	input logic nWE,
	input logic [23:1] A,
	output logic ioReq, // one clock per request
	output warpPkg::ioOpT ioOp,
	output logic [23:1] ioAddr,
	input logic ioCredit, // a queue slot came free
	input logic ioDone, // completions arrive in issue order
	output logic ioDtack, // active low
	output warpPkg::bridgeStateT bridgeState
);
	import warpPkg::*;

	localparam int CntW = `WARP_CREDIT_W + 1; // queued plus in service
	localparam logic [`WARP_CREDIT_W-1:0] FullCredits = `WARP_IO_CREDITS;
	localparam logic [CntW-1:0] LastDone = 1;

	bridgeStateT state;
	logic [`WARP_CREDIT_W-1:0] credits; // free queue slots
	logic [CntW-1:0] outstanding; // issued, no ioDone yet
	logic [CntW-1:0] waitLeft; // dones owed before this read completes
	logic newCycle; // fresh motherboard cycle
	logic issue; // request goes out this clock
	logic reqWrite; // posted, no completion wait

	assign newCycle = state == brIdle && BACT && IOCS;
	assign issue = (newCycle || state == brWaitCredit) && credits != '0;
	assign reqWrite = !nWE && !IACS;

	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			state <= brIdle;
			credits <= FullCredits;
			outstanding <= '0;
			waitLeft <= '0;
			ioReq <= 1'b0;
		end else begin
			ioReq <= issue;

			case ({issue, ioCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ; // spent and returned together
			endcase

			case ({issue, ioDone})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: ;
			endcase

			// reads count down to their own completion
			if (issue)
				waitLeft <= reqWrite ? '0 : (ioDone ? outstanding : outstanding + LastDone);
			else if (state == brWaitDone && ioDone)
				waitLeft <= waitLeft - LastDone;

			case (state)
				brIdle: if (newCycle)
					state <= issue ? brWaitDone : brWaitCredit;
				brWaitCredit: if (issue)
					state <= brWaitDone; // back-pressure lifted
				brWaitDone: if (waitLeft == '0 || (ioDone && waitLeft == LastDone))
					state <= brAck;
				brAck: if (cycleEnd)
					state <= brIdle;
				default: state <= brIdle;
			endcase
		end
	end

	// request payload, captured with the strobe
	always_ff @(posedge CLK) begin
		if (issue) begin
			ioAddr <= A;
			if (IACS)
				ioOp <= ioIack;
			else if (nWE)
				ioOp <= ioRd;
			else
				ioOp <= ioWr;
		end
	end

	assign ioDtack = state != brAck;
	assign bridgeState = state;

endmodule

//--- hdl/warpTop.sv
`timescale 1ns/1ps

module warpTop (
	input logic CLK,
	input logic nRES,
	input logic [23:1] A,
	input logic nAS,
	input logic nWE,
	input logic FastROMEN,
	output logic nDTACK, // merged acknowledge to the CPU
	output logic RAMCS,
	output logic ROMCS,
	output logic IOCS,
	output logic SCSICS,
	output logic IOPWCS,
	output logic IACS,
	output logic SndRAMCSWR,
	output logic ioReq,
	output warpPkg::ioOpT ioOp,
	output logic [23:1] ioAddr,
	input logic ioCredit,
	input logic ioDone,
	output warpPkg::bridgeStateT bridgeState // debug
);

	logic BACT;
	logic cycleEnd;
	logic fastDtack; // RAM/ROM path
	logic ioDtack; // motherboard path

	cycleDetect u_cycleDetect (
		.CLK(CLK),
		.nRES(nRES),
		.nAS(nAS),
		.BACT(BACT),
		.cycleEnd(cycleEnd)
	);

	CS u_CS (
		.FastROMEN(FastROMEN),
		.A(A[23:8]), // decode needs 256-byte granularity only
		.CLK(CLK),
		.nRES(nRES),
		.nWE(nWE),
		.BACT(BACT),
		.IOCS(IOCS),
		.SCSICS(SCSICS),
		.IOPWCS(IOPWCS),
		.IACS(IACS),
		.ROMCS(ROMCS),
		.RAMCS(RAMCS),
		.SndRAMCSWR(SndRAMCSWR)
	);

	fastAck u_fastAck (
		.CLK(CLK),
		.nRES(nRES),
		.BACT(BACT),
		.RAMCS(RAMCS),
		.ROMCS(ROMCS),
		.fastDtack(fastDtack)
	);

	ioBridge u_ioBridge (
		.CLK(CLK),
		.nRES(nRES),
		.BACT(BACT),
		.cycleEnd(cycleEnd),
		.IOCS(IOCS),
		.IACS(IACS),
		.nWE(nWE),
		.A(A),
		.ioReq(ioReq),
		.ioOp(ioOp),
		.ioAddr(ioAddr),
		.ioCredit(ioCredit),
		.ioDone(ioDone),
		.ioDtack(ioDtack),
		.bridgeState(bridgeState)
	);

	assign nDTACK = fastDtack & ioDtack; // either source may end the cycle

endmodule

//--- test/ioBusModel.sv
`timescale 1ns/1ps
`include "warp_settings.svh"

module ioBusModel #(
	parameter int StallCycles = 60 // service time of a stalled request
) (
	input logic CLK,
	input logic nRES,
	input logic ioReq,
	input warpPkg::ioOpT ioOp,
	input logic stall, // sampled with each request
	output logic ioCredit, // slot freed
	output logic ioDone, // in issue order
	output logic overflow // more requests than slots
);
	import warpPkg::*;

	ioOpT opQ[$]; // head is in service
	bit holdQ[$];
	int timer; // cycles left for the head
	bit busy;

	always @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			ioCredit <= 1'b0;
			ioDone <= 1'b0;
			overflow <= 1'b0;
			opQ.delete();
			holdQ.delete();
			busy = 0;
			timer = 0;
		end else begin
			ioCredit <= 1'b0;
			ioDone <= 1'b0;
			if (ioReq) begin
				opQ.push_back(ioOp);
				holdQ.push_back(stall);
			end
			overflow <= opQ.size() > `WARP_IO_CREDITS;
			if (busy) begin
				if (timer > 1)
					timer--;
				else begin
					ioCredit <= 1'b1; // head leaves the queue
					ioDone <= 1'b1;
					void'(opQ.pop_front());
					void'(holdQ.pop_front());
					busy = 0;
				end
			end else if (opQ.size() > 0) begin
				// motherboard reads and IACK never finish in one cycle
				if (holdQ[0])
					timer = StallCycles;
				else if (opQ[0] != ioWr)
					timer = 2 + $urandom % 5;
				else
					timer = 1 + $urandom % 6;
				busy = 1;
			end
		end
	end

endmodule

//--- test/tbWarp.sv
`timescale 1ns/1ps
`include "warp_settings.svh"

module tbWarp;
	import warpPkg::*;

	logic CLK;
	logic nRES;
	logic nAS;
	logic nWE;
	logic FastROMEN;
	logic stall; // tells the bus model to hold requests
	logic [23:1] A;
	logic nDTACK;
	logic RAMCS, ROMCS, IOCS, SCSICS, IOPWCS, IACS, SndRAMCSWR;
	logic ioReq, ioCredit, ioDone, overflow;
	logic [23:1] ioAddr;
	ioOpT ioOp;
	bridgeStateT bridgeState;

	string nameQ[$]; // one entry per pattern line
	logic [23:0] addrQ[$]; // byte address
	logic nweQ[$], froQ[$], stallQ[$], hasOpQ[$];
	logic [6:0] selQ[$]; // RAM ROM IO SCSI IOPW IACK SND
	ioOpT opQ[$];
	int numLines = 0;
	int reqCnt = 0; // ioReq pulses seen
	int doneCnt = 0;
	int creditCnt = 0;
	ioOpT lastOp; // op of the latest request
	logic [23:1] lastAddr; // address of the latest request

	always #20 CLK = ~CLK;

	warpTop u_warpTop (
		.CLK(CLK), .nRES(nRES), .A(A), .nAS(nAS), .nWE(nWE), .FastROMEN(FastROMEN),
		.nDTACK(nDTACK), .RAMCS(RAMCS), .ROMCS(ROMCS), .IOCS(IOCS), .SCSICS(SCSICS),
		.IOPWCS(IOPWCS), .IACS(IACS), .SndRAMCSWR(SndRAMCSWR),
		.ioReq(ioReq), .ioOp(ioOp), .ioAddr(ioAddr), .ioCredit(ioCredit),
		.ioDone(ioDone), .bridgeState(bridgeState)
	);

	ioBusModel u_ioBusModel (
		.CLK(CLK), .nRES(nRES), .ioReq(ioReq), .ioOp(ioOp), .stall(stall),
		.ioCredit(ioCredit), .ioDone(ioDone), .overflow(overflow)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic compareSel(input string name, input logic [6:0] expSel, input logic [6:0] actSel);
		if (actSel !== expSel)
			failRun($sformatf("error %s expected %b actual %b", name, expSel, actSel));
	endtask

	task automatic compareOp(input string name, input ioOpT expOp, input ioOpT actOp);
		if (actOp !== expOp)
			failRun($sformatf("error %s expected %s actual %s", name, expOp.name(), actOp.name()));
	endtask

	task automatic compareAddr(input string name, input logic [23:1] expAddr,
			input logic [23:1] actAddr);
		if (actAddr !== expAddr)
			failRun($sformatf("error %s expected %h actual %h", name, expAddr, actAddr));
	endtask

	task automatic compareState(input string name, input bridgeStateT expSt, input bridgeStateT actSt);
		if (actSt !== expSt)
			failRun($sformatf("error %s expected %s actual %s", name, expSt.name(), actSt.name()));
	endtask

	task automatic compareCycles(input string name, input int expCyc, input int actCyc);
		if (actCyc != expCyc)
			failRun($sformatf("error %s expected %0d actual %0d", name, expCyc, actCyc));
	endtask

	task automatic compareCount(input string name, input int expCnt, input int actCnt);
		if (actCnt != expCnt)
			failRun($sformatf("error %s expected %0d actual %0d", name, expCnt, actCnt));
	endtask

	// bus monitor, counts pulses on the I/O side
	always @(posedge CLK) begin
		if (ioReq) begin
			reqCnt++;
			lastOp = ioOp;
			lastAddr = ioAddr;
		end
		if (ioDone)
			doneCnt++;
		if (ioCredit)
			creditCnt++;
		if (reqCnt - creditCnt > `WARP_IO_CREDITS)
			failRun("more I/O requests in flight than credits");
		if (overflow)
			failRun("I/O bus model queue overflowed");
	end

	task automatic readPatterns;
		int fd;
		int n;
		string line, nm, opStr;
		logic [23:0] addr;
		logic nwe, fre, stl;
		logic [6:0] sel;
		fd = $fopen("test/warp_patterns.txt", "r");
		if (fd == 0)
			failRun("cannot open test/warp_patterns.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue; // blank or comment
			n = $sscanf(line, "%s %h %b %b %b %s %b", nm, addr, nwe, fre, sel, opStr, stl);
			if (n != 7)
				failRun({"malformed pattern line ", line});
			nameQ.push_back(nm);
			addrQ.push_back(addr);
			nweQ.push_back(nwe);
			froQ.push_back(fre);
			selQ.push_back(sel);
			stallQ.push_back(stl);
			hasOpQ.push_back(opStr != "none");
			case (opStr)
				"rd": opQ.push_back(ioRd);
				"wr": opQ.push_back(ioWr);
				"iack": opQ.push_back(ioIack);
				"none": opQ.push_back(ioRd); // never compared
				default: failRun({"unknown op in pattern ", nm});
			endcase
		end
		$fclose(fd);
		if (nameQ.size() == 0)
			failRun("pattern file holds no test lines");
		numLines = nameQ.size();
	endtask

	// one CPU bus cycle, strobe low until acknowledged
	task automatic runLine(input int i);
		int cnt;
		int reqStart;
		int fastExp;
		bridgeStateT expState;
		@(posedge CLK);
		A <= addrQ[i][23:1];
		nWE <= nweQ[i];
		FastROMEN <= froQ[i];
		stall <= stallQ[i];
		nAS <= 1'b0;
		repeat (2) @(posedge CLK); // strobe sampled, then BACT up
		@(negedge CLK);
		compareSel(nameQ[i], selQ[i], {RAMCS, ROMCS, IOCS, SCSICS, IOPWCS, IACS, SndRAMCSWR});
		reqStart = reqCnt;
		// queue full means the CPU gets held off
		expState = (reqCnt - creditCnt >= `WARP_IO_CREDITS) ? brWaitCredit : brWaitDone;
		cnt = 0;
		if (selQ[i] == '0) begin
			repeat (6) begin
				@(negedge CLK);
				if (nDTACK !== 1'b1)
					failRun({nameQ[i], " got nDTACK with nothing selected"});
			end
		end else begin
			do begin
				@(negedge CLK);
				cnt++;
				if (cnt == 1 && hasOpQ[i])
					compareState(nameQ[i], expState, bridgeState);
			end while (nDTACK);
		end
		if (!hasOpQ[i]) begin
			compareCount(nameQ[i], reqStart, reqCnt); // nothing sent to the I/O bus
			if (selQ[i] != '0)
				compareCycles(nameQ[i], `WARP_FAST_WAIT, cnt);
		end else begin
			compareCount(nameQ[i], reqStart + 1, reqCnt);
			compareOp(nameQ[i], opQ[i], lastOp);
			compareAddr(nameQ[i], addrQ[i][23:1], lastAddr);
			fastExp = (|selQ[i][6:5] && `WARP_FAST_WAIT < 2) ? `WARP_FAST_WAIT : 2;
			if (opQ[i] != ioWr)
				compareCount(nameQ[i], reqCnt, doneCnt); // all earlier writes done too
			else if (expState == brWaitDone)
				compareCycles(nameQ[i], fastExp, cnt); // posted, ack after ioReq
		end
		@(posedge CLK);
		nAS <= 1'b1;
		do
			@(negedge CLK);
		while (!nDTACK);
		repeat (2) @(posedge CLK); // idle gap, overlay may switch here
	endtask

	initial begin
		int seed;
		CLK = 1'b0;
		nRES = 1'b0;
		nAS = 1'b1;
		nWE = 1'b1;
		FastROMEN = 1'b1;
		stall = 1'b0;
		A = '0;
		seed = 59;
		void'($urandom(seed));
		readPatterns();
		repeat (8) @(posedge CLK);
		nRES <= 1'b1;
		@(negedge CLK);
		compareState("reset", brIdle, bridgeState);
		if (nDTACK !== 1'b1 || ioReq !== 1'b0)
			failRun("nDTACK or ioReq active right after reset");
		for (int i = 0; i < numLines; i++)
			runLine(i);
		$display("all tests passed");
		$finish;
	end

	// watchdog sized from the pattern count
	initial begin
		wait (numLines > 0);
		repeat (numLines * 200) @(posedge CLK);
		failRun($sformatf("timeout, run still busy after %0d cycles", numLines * 200));
	end

endmodule

//--- test/warp_patterns.txt
# name addr(hex byte) nWE FastROMEN sel(RAM ROM IO SCSI IOPW IACK SND) op(rd/wr/iack/none) stall
# one CPU bus cycle per line, stall=1 makes the I/O bus hold that request long
ovlRomFast 000000 1 1 0100000 none 0
ovlRomMb 000000 1 0 0010000 rd 0
ovlRamHigh 600000 1 1 1000000 none 0
ovlRamHighWr 600100 0 1 1000000 none 0
romFirst 400000 1 1 0100000 none 0
relLowRam 000000 1 1 1000000 none 0
relHighEmpty 600000 1 1 0000000 none 0
lowRamWr 012340 0 1 1000100 none 0
lowRamRd 012340 1 1 1000000 none 0
topRamWr 3F9000 0 1 1000100 none 0
romFast 40A000 1 1 0100000 none 0
romMb 40A000 1 0 0010000 rd 0
romAltFast C00000 1 0 0100000 none 0
romAltMb C00000 1 1 0010000 rd 0
scsiRd 580000 1 1 0011000 rd 0
sccRd 9FFFF8 1 1 0010000 rd 0
sccWr BFFFF9 0 1 0010000 wr 0
iwmRd DFE1FF 1 1 0010000 rd 0
viaWr EFE1FE 0 1 0010000 wr 0
emptyRd 800000 1 1 0010000 rd 0
iackRd FFFFFE 1 1 0010010 iack 0
vidSndWr 3FA100 0 1 1010101 wr 0
sndMainWr 3FFD00 0 1 1010101 wr 0
burstWr1 EFE1FE 0 1 0010000 wr 1
burstWr2 BFFFF9 0 1 0010000 wr 1
burstWr3 EFE1FE 0 1 0010000 wr 1
burstWr4 BFFFF9 0 1 0010000 wr 1
burstWr5 EFE1FE 0 1 0010000 wr 1
burstWr6 BFFFF9 0 1 0010000 wr 1
rdBehind 9FFFF8 1 1 0010000 rd 0
postWr1 EFE1FE 0 1 0010000 wr 1
postWr2 BFFFF9 0 1 0010000 wr 1
iackBehind FFFFFE 1 1 0010010 iack 0

//--- all.f
+incdir+include
hdl/warpPkg.sv
hdl/cycleDetect.sv
hdl/CS.sv
hdl/fastAck.sv
hdl/ioBridge.sv
hdl/warpTop.sv
test/ioBusModel.sv
test/tbWarp.sv

//--- Bender.yml
package:
  name: warp

sources:
  - include_dirs:
      - include
    files:
      - hdl/warpPkg.sv
      - hdl/cycleDetect.sv
      - hdl/CS.sv
      - hdl/fastAck.sv
      - hdl/ioBridge.sv
      - hdl/warpTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ioBusModel.sv
      - test/tbWarp.sv
